//--- common/cpu_pkg.sv
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_addr_t;

	typedef enum logic [3:0] {
		OP_BNE    = 4'd0,
		OP_BEQ    = 4'd1,
		OP_BGZ    = 4'd2,
		OP_BLZ    = 4'd3,
		OP_ADI    = 4'd4,
		OP_ORI    = 4'd5,
		OP_LHI    = 4'd6,
		OP_LWD    = 4'd7,
		OP_SWD    = 4'd8,
		OP_JMP    = 4'd9,
		OP_R_TYPE = 4'd15
	} opcode_e;

	// function field of R-format words
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

	typedef enum logic [1:0] {XFER_NONE, XFER_BRANCH, XFER_JUMP} xfer_e;

	typedef struct packed {
		logic valid;      // cleared for bubbles
		logic uses_rs;
		logic uses_rt;
		logic alu_src_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		xfer_e xfer;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		opcode_e opcode;
		func_e func;
		word_t pc;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t rs_data;
		word_t rt_data;
		word_t imm_ext;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		opcode_e opcode;
		func_e func;
		word_t alu_result;
		word_t store_data; // rt for SWD, rs for WWD
		reg_addr_t rd;
		logic taken;
		word_t target;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		func_e func;
		opcode_e opcode;
		word_t wb_data;
		reg_addr_t rd;
		word_t store_data;
	} mem_wb_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input word_t a,
	input word_t b,
	input opcode_e opcode,
	input func_e func,
	output word_t result,
	output logic bcond
);

	always_comb begin
		case (opcode)
			OP_ADI, OP_LWD, OP_SWD: result = a + b; // also the memory address
			OP_ORI: result = a | b;
			OP_LHI: result = b;
			OP_R_TYPE: begin
				case (func)
					FN_ADD: result = a + b;
					FN_SUB: result = a - b;
					FN_AND: result = a & b;
					FN_ORR: result = a | b;
					FN_NOT: result = ~a;
					FN_TCP: result = ~a + 16'd1;
					FN_SHL: result = {a[14:0], 1'b0};
					FN_SHR: result = {a[15], a[15:1]}; // arithmetic
					FN_WWD: result = a;
					default: result = '0;
				endcase
			end
			default: result = '0;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_BNE: bcond = (a != b);
			OP_BEQ: bcond = (a == b);
			OP_BGZ: bcond = !a[15] && (a != '0);
			OP_BLZ: bcond = a[15];
			default: bcond = 1'b0;
		endcase
	end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input reg_addr_t id_rs,
	input reg_addr_t id_rt,
	input ctrl_t id_ctrl,
	input reg_addr_t ex_rs,
	input reg_addr_t ex_rt,
	input reg_addr_t ex_dest,
	input ctrl_t ex_ctrl,
	input reg_addr_t mem_dest,
	input reg_addr_t wb_dest,
	input logic mem_reg_write,
	input logic wb_reg_write,
	output logic stall,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b
);

	logic load_in_ex;

	// nearest producer wins
	function automatic fwd_sel_e pick_source(input reg_addr_t src);
		fwd_sel_e sel;
		if (mem_reg_write && mem_dest == src) begin
			sel = FWD_MEM;
		end else if (wb_reg_write && wb_dest == src) begin
			sel = FWD_WB;
		end else begin
			sel = FWD_REG;
		end
		return sel;
	endfunction

	assign load_in_ex = ex_ctrl.valid && ex_ctrl.mem_read;

	// load result is not ready until WB, so hold the consumer one cycle
	assign stall = load_in_ex && id_ctrl.valid
		&& ((id_ctrl.uses_rs && id_rs == ex_dest) || (id_ctrl.uses_rt && id_rt == ex_dest));

	assign fwd_a = pick_source(ex_rs);
	assign fwd_b = pick_source(ex_rt);

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input logic clk,
	input reg_addr_t rs,
	input reg_addr_t rt,
	input reg_addr_t wr_addr,
	input logic wr_en,
	input word_t wr_data,
	output word_t rs_data,
	output word_t rt_data
);

	word_t regs [4];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through so an ID read sees the WB result in the same cycle
	assign rs_data = (wr_en && wr_addr == rs) ? wr_data : regs[rs];
	assign rt_data = (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

//--- core/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
	input word_t instr,
	input word_t pc,
	output ctrl_t ctrl,
	output opcode_e opcode,
	output func_e func,
	output reg_addr_t rs,
	output reg_addr_t rt,
	output reg_addr_t dest,
	output word_t imm_ext
);

	logic [7:0] imm8;

	assign opcode = opcode_e'(instr[15:12]);
	assign func = func_e'(instr[5:0]);
	assign rs = instr[11:10];
	assign rt = instr[9:8];
	assign imm8 = instr[7:0];

	// R-format writes rd, I-format writes rt
	assign dest = (opcode == OP_R_TYPE) ? instr[7:6] : instr[9:8];

	always_comb begin
		case (opcode)
			OP_ORI: imm_ext = {8'h00, imm8};
			OP_LHI: imm_ext = {imm8, 8'h00};
			OP_JMP: imm_ext = {pc[15:12], instr[11:0]};
			default: imm_ext = {{8{imm8[7]}}, imm8};
		endcase
	end

	always_comb begin
		ctrl = '0; // unknown words stay invalid
		case (opcode)
			OP_BNE, OP_BEQ: begin
				ctrl.valid = 1'b1;
				ctrl.uses_rs = 1'b1;
				ctrl.uses_rt = 1'b1;
				ctrl.xfer = XFER_BRANCH;
			end
			OP_BGZ, OP_BLZ: begin
				ctrl.valid = 1'b1;
				ctrl.uses_rs = 1'b1;
				ctrl.xfer = XFER_BRANCH;
			end
			OP_ADI, OP_ORI: begin
				ctrl.valid = 1'b1;
				ctrl.uses_rs = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_LHI: begin
				ctrl.valid = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_LWD: begin
				ctrl.valid = 1'b1;
				ctrl.uses_rs = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_SWD: begin
				ctrl.valid = 1'b1;
				ctrl.uses_rs = 1'b1;
				ctrl.uses_rt = 1'b1; // store data
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_JMP: begin
				ctrl.valid = 1'b1;
				ctrl.xfer = XFER_JUMP;
			end
			OP_R_TYPE: begin
				case (func)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						ctrl.valid = 1'b1;
						ctrl.uses_rs = 1'b1;
						ctrl.uses_rt = 1'b1;
						ctrl.reg_write = 1'b1;
					end
					FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						ctrl.valid = 1'b1;
						ctrl.uses_rs = 1'b1;
						ctrl.reg_write = 1'b1;
					end
					FN_WWD: begin
						ctrl.valid = 1'b1;
						ctrl.uses_rs = 1'b1;
					end
					FN_HLT: ctrl.valid = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic hold,
	input id_ex_t id_ex,
	input fwd_sel_e fwd_a,
	input fwd_sel_e fwd_b,
	input word_t mem_fwd,
	input word_t wb_fwd,
	output ex_mem_t ex_mem
);

	word_t src_a;
	word_t src_b;
	word_t op_b;
	word_t alu_result;
	word_t target;
	word_t store_data;
	logic bcond;
	logic taken;
	logic is_wwd;

	always_comb begin
		case (fwd_a)
			FWD_MEM: src_a = mem_fwd;
			FWD_WB: src_a = wb_fwd;
			default: src_a = id_ex.rs_data;
		endcase
		case (fwd_b)
			FWD_MEM: src_b = mem_fwd;
			FWD_WB: src_b = wb_fwd;
			default: src_b = id_ex.rt_data;
		endcase
	end

	assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : src_b;

	alu alu_inst (
		.a(src_a),
		.b(op_b),
		.opcode(id_ex.opcode),
		.func(id_ex.func),
		.result(alu_result),
		.bcond(bcond)
	);

	// jump target is already complete from decode
	assign target = (id_ex.ctrl.xfer == XFER_JUMP) ? id_ex.imm_ext
		: id_ex.pc + 16'd1 + id_ex.imm_ext;

	assign taken = id_ex.ctrl.valid && (id_ex.ctrl.xfer == XFER_JUMP
		|| (id_ex.ctrl.xfer == XFER_BRANCH && bcond));

	assign is_wwd = id_ex.opcode == OP_R_TYPE && id_ex.func == FN_WWD;
	assign store_data = is_wwd ? src_a : src_b; // WWD sends rs out through the store path

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem.ctrl <= '0;
			ex_mem.taken <= 1'b0;
		end else if (!hold) begin
			if (flush) begin
				ex_mem.ctrl <= '0;
				ex_mem.taken <= 1'b0;
			end else begin
				ex_mem <= '{
					ctrl: id_ex.ctrl,
					opcode: id_ex.opcode,
					func: id_ex.func,
					alu_result: alu_result,
					store_data: store_data,
					rd: id_ex.rd,
					taken: taken,
					target: target
				};
			end
		end
	end

endmodule

//--- core/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
	parameter word_t RESET_PC = 16'h0000
) (
	input logic clk,
	input logic reset,
	output word_t imem_addr,
	input word_t imem_rdata,
	output logic dmem_read,
	output logic dmem_write,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	input word_t dmem_rdata,
	output word_t output_port,
	output word_t num_inst,
	output logic halted
);

	word_t pc;
	word_t if_pc;
	word_t if_instr;
	logic if_valid;

	ctrl_t dec_ctrl;
	ctrl_t id_ctrl;
	opcode_e id_opcode;
	func_e id_func;
	reg_addr_t id_rs;
	reg_addr_t id_rt;
	reg_addr_t id_dest;
	word_t id_imm;
	word_t rs_data;
	word_t rt_data;

	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	logic stall;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	logic flush;
	logic wb_hlt;
	logic wb_wwd;
	logic freeze;
	word_t wb_data;

	assign flush = ex_mem.taken;
	assign wb_hlt = mem_wb.ctrl.valid && mem_wb.opcode == OP_R_TYPE && mem_wb.func == FN_HLT;
	assign wb_wwd = mem_wb.ctrl.valid && mem_wb.opcode == OP_R_TYPE && mem_wb.func == FN_WWD;
	assign freeze = halted || wb_hlt; // stop everything once HLT reaches WB

	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (!freeze) begin
			if (flush) begin
				pc <= ex_mem.target;
			end else if (!stall) begin
				pc <= pc + 16'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			if_valid <= 1'b0;
		end else if (!freeze) begin
			if (flush) begin
				if_valid <= 1'b0;
			end else if (!stall) begin
				if_valid <= 1'b1;
				if_pc <= pc;
				if_instr <= imem_rdata;
			end
		end
	end

	decode_unit decode_unit_inst (
		.instr(if_instr),
		.pc(if_pc),
		.ctrl(dec_ctrl),
		.opcode(id_opcode),
		.func(id_func),
		.rs(id_rs),
		.rt(id_rt),
		.dest(id_dest),
		.imm_ext(id_imm)
	);

	// an empty IF/ID slot reads as word 0, which would decode as BNE
	assign id_ctrl = if_valid ? dec_ctrl : '0;

	register_file register_file_inst (
		.clk(clk),
		.rs(id_rs),
		.rt(id_rt),
		.wr_addr(mem_wb.rd),
		.wr_en(mem_wb.ctrl.reg_write && !halted),
		.wr_data(mem_wb.wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	hazard_unit hazard_unit_inst (
		.id_rs(id_rs),
		.id_rt(id_rt),
		.id_ctrl(id_ctrl),
		.ex_rs(id_ex.rs),
		.ex_rt(id_ex.rt),
		.ex_dest(id_ex.rd),
		.ex_ctrl(id_ex.ctrl),
		.mem_dest(ex_mem.rd),
		.wb_dest(mem_wb.rd),
		.mem_reg_write(ex_mem.ctrl.reg_write),
		.wb_reg_write(mem_wb.ctrl.reg_write),
		.stall(stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex.ctrl <= '0;
		end else if (!freeze) begin
			if (flush || stall) begin
				id_ex.ctrl <= '0; // bubble
			end else begin
				id_ex <= '{
					ctrl: id_ctrl,
					opcode: id_opcode,
					func: id_func,
					pc: if_pc,
					rs: id_rs,
					rt: id_rt,
					rd: id_dest,
					rs_data: rs_data,
					rt_data: rt_data,
					imm_ext: id_imm
				};
			end
		end
	end

	execute_stage execute_stage_inst (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.hold(freeze),
		.id_ex(id_ex),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.mem_fwd(ex_mem.alu_result),
		.wb_fwd(mem_wb.wb_data),
		.ex_mem(ex_mem)
	);

	// data port, same-cycle read
	assign dmem_read = ex_mem.ctrl.mem_read && !freeze;
	assign dmem_write = ex_mem.ctrl.mem_write && !freeze;
	assign dmem_addr = ex_mem.alu_result;
	assign dmem_wdata = ex_mem.store_data;

	assign wb_data = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb.ctrl <= '0;
		end else if (!freeze) begin
			mem_wb <= '{
				ctrl: ex_mem.ctrl,
				func: ex_mem.func,
				opcode: ex_mem.opcode,
				wb_data: wb_data,
				rd: ex_mem.rd,
				store_data: ex_mem.store_data
			};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
			output_port <= '0;
			num_inst <= '0;
		end else if (!halted) begin
			if (mem_wb.ctrl.valid) begin
				num_inst <= num_inst + 16'd1; // HLT itself is counted
			end
			if (wb_wwd) begin
				output_port <= mem_wb.store_data;
			end
			if (wb_hlt) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

//--- dv/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

	localparam int SEED = 32'h34de_667f;
	localparam int CYCLES_PER_WORD = 20;
	localparam int TIMEOUT_SLACK = 100;
	localparam int MEM_WORDS = 256;
	localparam DATA_FILE = "dv/cpu_testdata.txt";

	logic clk;
	logic reset;
	word_t imem_addr;
	word_t imem_rdata;
	logic dmem_read;
	logic dmem_write;
	word_t dmem_addr;
	word_t dmem_wdata;
	word_t dmem_rdata;
	word_t output_port;
	word_t num_inst;
	logic halted;

	word_t imem [MEM_WORDS];
	word_t dmem [MEM_WORDS];

	word_t wwd_exp [64];
	int wwd_test [64]; // test number each WWD value belongs to
	int wwd_count;
	int wwd_idx;
	word_t store_addr [16];
	word_t store_data [16];
	int store_count;
	int store_idx;
	word_t final_addr [16];
	word_t final_data [16];
	int final_count;
	word_t exp_num_inst;
	int prog_words;
	int cycle_limit;
	int cycle_count;

	int errors;
	int test_errors;
	int failed_tests;
	int current_test;
	logic running;
	logic halt_seen;
	word_t last_port;

	cpu_core #(.RESET_PC(16'h0000)) cpu_core_inst (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.output_port(output_port),
		.num_inst(num_inst),
		.halted(halted)
	);

	// both memories answer in the same cycle
	assign imem_rdata = imem[imem_addr[7:0]];
	assign dmem_rdata = dmem_read ? dmem[dmem_addr[7:0]] : 16'hxxxx; // unknown unless read

	always @(posedge clk) begin
		if (dmem_write) begin
			dmem[dmem_addr[7:0]] <= dmem_wdata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: core did not halt within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		errors++;
		test_errors++;
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
		test_errors++;
	endtask

	function automatic string test_name(input int t);
		case (t)
			1: return "reset values";
			2: return "arithmetic and forwarding";
			3: return "load-use and memory";
			4: return "branches and jumps";
			default: return "halt and count";
		endcase
	endfunction

	task automatic finish_test;
		if (test_errors == 0) begin
			$display("test %0d, %s: ok", current_test, test_name(current_test));
		end else begin
			$display("test %0d, %s: %0d error(s)", current_test, test_name(current_test),
				test_errors);
			failed_tests++;
		end
		test_errors = 0;
		current_test++;
	endtask

	task automatic read_data_file;
		int fd;
		int n;
		int ch;
		logic [7:0] tag;
		word_t col_a;
		word_t col_b;
		logic done;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			report_error($sformatf("cannot open %s", DATA_FILE));
		end else begin
			done = 1'b0;
			while (!done) begin
				n = $fscanf(fd, " %c", tag);
				if (n != 1) begin
					done = 1'b1;
				end else if (tag == "#") begin
					ch = 0;
					while (ch != 10 && ch != -1) begin
						ch = $fgetc(fd); // rest of a comment
					end
				end else begin
					n = $fscanf(fd, "%h %h", col_a, col_b);
					case (tag)
						"I": begin
							imem[col_a[7:0]] = col_b;
							if (col_a + 1 > prog_words) begin
								prog_words = col_a + 1;
							end
						end
						"D": dmem[col_a[7:0]] = col_b;
						"W": begin
							wwd_test[wwd_count] = col_a;
							wwd_exp[wwd_count] = col_b;
							wwd_count++;
						end
						"S": begin
							store_addr[store_count] = col_a;
							store_data[store_count] = col_b;
							store_count++;
						end
						"N": exp_num_inst = col_b;
						"M": begin
							final_addr[final_count] = col_a;
							final_data[final_count] = col_b;
							final_count++;
						end
						default: report_error("unknown tag in test data");
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_reset_outputs;
		if (halted !== 1'b0) begin
			report_mismatch("halted", 16'd0, halted);
		end
		if (num_inst !== 16'd0) begin
			report_mismatch("num_inst", 16'd0, num_inst);
		end
		if (output_port !== 16'd0) begin
			report_mismatch("output_port", 16'd0, output_port);
		end
		if (dmem_read !== 1'b0) begin
			report_mismatch("dmem_read", 16'd0, dmem_read);
		end
		if (dmem_write !== 1'b0) begin
			report_mismatch("dmem_write", 16'd0, dmem_write);
		end
	endtask

	task automatic check_store;
		if (store_idx >= store_count) begin
			report_error($sformatf("unexpected data write to address %h", dmem_addr));
		end else begin
			if (dmem_addr !== store_addr[store_idx]) begin
				report_mismatch("dmem_addr", store_addr[store_idx], dmem_addr);
			end
			if (dmem_wdata !== store_data[store_idx]) begin
				report_mismatch("dmem_wdata", store_data[store_idx], dmem_wdata);
			end
			store_idx++;
		end
	endtask

	task automatic check_output_port;
		if (wwd_idx >= wwd_count) begin
			report_error($sformatf("output_port changed to %h with no WWD left", output_port));
		end else begin
			if (output_port !== wwd_exp[wwd_idx]) begin
				report_mismatch("output_port", wwd_exp[wwd_idx], output_port);
			end
			wwd_idx++;
			if (wwd_idx == wwd_count) begin
				finish_test();
			end else if (wwd_test[wwd_idx] != wwd_test[wwd_idx - 1]) begin
				finish_test(); // last value of this test seen
			end
		end
	endtask

	always @(negedge clk) begin
		if (running) begin
			if (dmem_write) begin
				check_store();
			end
			if (output_port !== last_port) begin
				if (halt_seen) begin
					report_error("output_port changed after halt");
				end else begin
					check_output_port();
				end
				last_port = output_port;
			end
			if (halted) begin
				halt_seen = 1'b1;
			end
		end
	end

	initial begin
		int seed_init;
		int i;
		reset = 1'b1;
		errors = 0;
		test_errors = 0;
		failed_tests = 0;
		current_test = 1;
		running = 1'b0;
		halt_seen = 1'b0;
		last_port = '0;
		wwd_count = 0;
		wwd_idx = 0;
		store_count = 0;
		store_idx = 0;
		final_count = 0;
		exp_num_inst = '0;
		prog_words = 0;
		cycle_count = 0;
		cycle_limit = TIMEOUT_SLACK;
		seed_init = $urandom(SEED);
		for (i = 0; i < MEM_WORDS; i++) begin
			imem[i] = 16'hF01D; // HLT past the program
			dmem[i] = $urandom;
		end
		read_data_file();
		cycle_limit = CYCLES_PER_WORD * prog_words + TIMEOUT_SLACK;

		repeat (3) begin
			@(negedge clk);
			check_reset_outputs();
		end
		@(posedge clk);
		#1 reset = 1'b0;
		running = 1'b1;
		@(negedge clk);
		check_reset_outputs();
		finish_test();

		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		repeat (10) @(negedge clk); // port must stay still while frozen
		while (current_test < 5) begin
			report_error("expected WWD values never appeared");
			finish_test();
		end

		if (halted !== 1'b1) begin
			report_error("halted dropped after it rose");
		end
		if (num_inst !== exp_num_inst) begin
			report_mismatch("num_inst", exp_num_inst, num_inst);
		end
		if (store_idx != store_count) begin
			report_error("fewer data writes than expected");
		end
		for (i = 0; i < final_count; i++) begin
			if (dmem[final_addr[i][7:0]] !== final_data[i]) begin
				report_mismatch($sformatf("dmem[%h]", final_addr[i]), final_data[i],
					dmem[final_addr[i][7:0]]);
			end
		end
		finish_test();

		$display("%0d tests, %0d failed, %0d errors", current_test - 1, failed_tests, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- dv/cpu_testdata.txt
# tag, then two hex columns: I addr instr, D addr data, W test value, S addr data,
# N 0 retire count, M addr data (final memory); text after # is ignored
I 00 6112  # lhi r1 12
I 01 5534  # ori r1 r1 34
I 02 F41C  # wwd r1
I 03 46FF  # adi r2 r1 -1
I 04 F6C1  # sub r3 r1 r2
I 05 FDC0  # add r3 r3 r1
I 06 FC1C  # wwd r3
I 07 FC05  # tcp r0 r3
I 08 F007  # shr r0 r0
I 09 F01C  # wwd r0
I 0A F044  # not r1 r0
I 0B F446  # shl r1 r1
I 0C F682  # and r2 r1 r2
I 0D F883  # orr r2 r2 r0
I 0E F81C  # wwd r2
I 0F 6000  # lhi r0 0
I 10 5040  # ori r0 r0 40
I 11 8200  # swd r2 [r0+0]
I 12 8301  # swd r3 [r0+1]
I 13 7100  # lwd r1 [r0+0]
I 14 F540  # add r1 r1 r1, load-use
I 15 F41C  # wwd r1
I 16 7301  # lwd r3 [r0+1]
I 17 8302  # swd r3 [r0+2], load-use on store data
I 18 7210  # lwd r2 [r0+10]
I 19 F81C  # wwd r2, load-use
I 1A 0B02  # bne r2 r3 taken
I 1B F41C  # skipped
I 1C FC1C  # skipped
I 1D 1B02  # beq r2 r3 not taken
I 1E FC1C  # wwd r3
I 1F 2C01  # bgz r3 taken
I 20 F41C  # skipped
I 21 3401  # blz r1 taken
I 22 F81C  # skipped
I 23 3C01  # blz r3 not taken
I 24 2401  # bgz r1 not taken
I 25 9028  # jmp 28
I 26 F41C  # skipped
I 27 F81C  # skipped
I 28 4FFF  # adi r3 r3 -1
I 29 0D01  # bne r3 r1 taken
I 2A F81C  # skipped
I 2B FC1C  # wwd r3
I 2C F01D  # hlt
I 2D F41C  # behind hlt
D 50 0777
W 2 1234
W 2 1235
W 2 F6E5
W 2 F6F5
W 3 EDEA
W 3 0777
W 4 1235
W 4 1234
S 0040 F6F5
S 0041 1235
S 0042 1235
N 0 0026
M 0040 F6F5
M 0041 1235
M 0042 1235
M 0050 0777

//--- flist.f
common/cpu_pkg.sv
logic/alu.sv
logic/hazard_unit.sv
logic/register_file.sv
core/decode_unit.sv
core/execute_stage.sv
core/cpu_core.sv
dv/tb_cpu.sv
